// File: Bender.yml
package:
  name: bmu_execute

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/bmuPkg.sv
      - rtl/aluCore.sv
      - rtl/zbbUnit.sv
      - rtl/clmulUnit.sv
      - rtl/bitManipAlu.sv
      - rtl/bmuExecute.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - test/bmuExecute_checker.sv
      - test/bmuExecute_tb.sv

// File: bmuExecute.f
+incdir+rtl
rtl/bmuPkg.sv
rtl/aluCore.sv
rtl/zbbUnit.sv
rtl/clmulUnit.sv
rtl/bitManipAlu.sv
rtl/bmuExecute.sv
test/bmuExecute_checker.sv
test/bmuExecute_tb.sv

// File: rtl/aluCore.sv
// Base integer datapath with shared adder, barrel shifter, logic ops and compare flags
`timescale 1ns/1ps
`include "bmu_macros.svh"

module aluCore (
  input  bmuPkg::aluOpT           op,
  input  logic [`BMU_XLEN-1:0]    a,
  input  logic [`BMU_XLEN-1:0]    condShiftA,  // A after shNadd pre-shift
  input  logic [`BMU_XLEN-1:0]    condMaskB,   // B, or one-hot mask for Zbs
  input  logic [`BMU_XLEN-1:0]    b,
  output logic [`BMU_XLEN-1:0]    aluResult,
  output logic                    lt,          // Signed a < b
  output logic                    ltu          // Unsigned a < b
);
  import bmuPkg::*;

  logic                    subtract;  // Invert B, carry in one
  logic [`BMU_XLEN:0]      sum;       // Carry out on top
  logic [`BMU_SHAMTW-1:0]  shamt;
  logic                    shLeft;
  logic                    shFill;    // Sign fill for sra
  logic [`BMU_XLEN-1:0]    shIn;
  logic [2*`BMU_XLEN-1:0]  shWide;
  logic [`BMU_XLEN-1:0]    shRes;

  ////////////////////
  // Adder
  ////////////////////
  // Min/max need the compare flags too
  assign subtract = op inside {OP_SUB, OP_SLT, OP_SLTU, OP_MIN, OP_MAX, OP_MINU, OP_MAXU};
  assign sum = {1'b0, condShiftA} + {1'b0, subtract ? ~b : b} + {{`BMU_XLEN{1'b0}}, subtract};

  assign ltu = ~sum[`BMU_XLEN];  // No carry out means borrow
  assign lt  = (condShiftA[`BMU_XLEN-1] != b[`BMU_XLEN-1]) ? condShiftA[`BMU_XLEN-1]
                                                          : sum[`BMU_XLEN-1];

  ////////////////////
  // Shifter
  ////////////////////
  // Right shifter only, left shift by reversing in and out
  assign shamt  = b[`BMU_SHAMTW-1:0];
  assign shLeft = (op == OP_SLL);
  assign shFill = (op == OP_SRA) & a[`BMU_XLEN-1];
  assign shWide = {{`BMU_XLEN{shFill}}, shIn} >> shamt;

  always_comb begin
    for (int i = 0; i < `BMU_XLEN; i++) begin
      shIn[i]  = shLeft ? a[`BMU_XLEN-1-i] : a[i];
      shRes[i] = shLeft ? shWide[`BMU_XLEN-1-i] : shWide[i];
    end
  end

  // Result select
  always_comb begin
    case (op)
      OP_SLT:             aluResult = {{(`BMU_XLEN-1){1'b0}}, lt};
      OP_SLTU:            aluResult = {{(`BMU_XLEN-1){1'b0}}, ltu};
      OP_SLL, OP_SRL,
      OP_SRA:             aluResult = shRes;
      OP_BEXT:            aluResult = {{(`BMU_XLEN-1){1'b0}}, shRes[0]};  // Bit 0 of a >> idx
      OP_AND:             aluResult = a & condMaskB;
      OP_ANDN, OP_BCLR:   aluResult = a & ~condMaskB;
      OP_OR, OP_BSET:     aluResult = a | condMaskB;
      OP_ORN:             aluResult = a | ~condMaskB;
      OP_XOR, OP_BINV:    aluResult = a ^ condMaskB;
      OP_XNOR:            aluResult = ~(a ^ condMaskB);
      default:            aluResult = sum[`BMU_XLEN-1:0];  // add, sub, shNadd
    endcase
  end

endmodule

// File: rtl/bitManipAlu.sv
// Bit-manipulation wrapper with operand pre-shift and mask, Zbb/Zbc units and result select
`timescale 1ns/1ps
`include "bmu_macros.svh"

module bitManipAlu (
  input  bmuPkg::aluOpT         op,
  input  logic [`BMU_XLEN-1:0]  a,
  input  logic [`BMU_XLEN-1:0]  b,
  input  logic                  active,      // Stage holds a valid command
  input  logic [`BMU_XLEN-1:0]  aluResult,
  input  logic                  lt,
  input  logic                  ltu,
  output logic [`BMU_XLEN-1:0]  condShiftA,
  output logic [`BMU_XLEN-1:0]  condMaskB,
  output logic [`BMU_XLEN-1:0]  result
);
  import bmuPkg::*;

  logic [1:0]            preShiftAmt;  // shNadd amount
  logic                  maskEn;       // Zbs single-bit ops
  zbbSelT                zbbSel;
  logic [1:0]            zbbSub;
  clmulSelT              clmulSel;
  resSelT                resSel;
  logic [`BMU_XLEN-1:0]  maskB;        // One-hot from b index
  logic [`BMU_XLEN-1:0]  aGated;
  logic [`BMU_XLEN-1:0]  bGated;
  logic [`BMU_XLEN-1:0]  zbbResult;
  logic [`BMU_XLEN-1:0]  clmulResult;

  ////////////////////
  // Decode
  ////////////////////
  always_comb begin
    case (op)
      OP_SH1ADD: preShiftAmt = 2'd1;
      OP_SH2ADD: preShiftAmt = 2'd2;
      OP_SH3ADD: preShiftAmt = 2'd3;
      default:   preShiftAmt = 2'd0;
    endcase
  end

  assign maskEn = op inside {OP_BSET, OP_BCLR, OP_BINV};

  always_comb begin
    case (op)
      OP_CLZ, OP_CTZ, OP_CPOP:          zbbSel = ZBB_COUNT;
      OP_MIN, OP_MAX, OP_MINU, OP_MAXU: zbbSel = ZBB_MINMAX;
      OP_SEXTB, OP_SEXTH, OP_ZEXTH:     zbbSel = ZBB_EXTEND;
      OP_ROL, OP_ROR:                   zbbSel = ZBB_ROTATE;
      OP_ORCB:                          zbbSel = ZBB_ORCB;
      default:                          zbbSel = ZBB_REV8;
    endcase
    // Position inside the group
    case (op)
      OP_CTZ, OP_MAX, OP_SEXTH, OP_ROR: zbbSub = 2'd1;
      OP_CPOP, OP_MINU, OP_ZEXTH:       zbbSub = 2'd2;
      OP_MAXU:                          zbbSub = 2'd3;
      default:                          zbbSub = 2'd0;
    endcase
  end

  assign clmulSel = (op == OP_CLMULH) ? CLMUL_HI :
                    (op == OP_CLMULR) ? CLMUL_REV : CLMUL_LO;

  always_comb begin
    if (op inside {OP_CLMUL, OP_CLMULH, OP_CLMULR}) begin
      resSel = RES_ZBC;
    end else if (op inside {OP_CLZ, OP_CTZ, OP_CPOP, OP_MIN, OP_MAX, OP_MINU, OP_MAXU,
                            OP_SEXTB, OP_SEXTH, OP_ZEXTH, OP_ROL, OP_ROR,
                            OP_ORCB, OP_REV8}) begin
      resSel = RES_ZBB;
    end else begin
      resSel = RES_ALU;
    end
  end

  ////////////////////
  // Operand prep
  ////////////////////
  assign maskB      = {{(`BMU_XLEN-1){1'b0}}, 1'b1} << b[`BMU_SHAMTW-1:0];
  assign condMaskB  = maskEn ? maskB : b;
  assign condShiftA = a << preShiftAmt;

  // Idle stage keeps Zbb/Zbc inputs quiet
  assign aGated = a & {`BMU_XLEN{active}};
  assign bGated = b & {`BMU_XLEN{active}};

  zbbUnit zbb0 (
    .a(aGated), .b(bGated), .zbbSel(zbbSel), .sub(zbbSub),
    .lt(lt), .ltu(ltu), .zbbResult(zbbResult)
  );

  clmulUnit clmul0 (
    .a(aGated), .b(bGated), .clmulSel(clmulSel), .clmulResult(clmulResult)
  );

  always_comb begin
    case (resSel)
      RES_ZBB: result = zbbResult;
      RES_ZBC: result = clmulResult;
      default: result = aluResult;  // Base, Zba, Zbs, Zbb logic
    endcase
  end

endmodule

// File: rtl/bmuExecute.sv
// Execute-stage top level with operand and result registers around the ALU datapath
`timescale 1ns/1ps
`include "bmu_macros.svh"

module bmuExecute (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  inValid,   // One strobe per command
  input  bmuPkg::aluOpT         op,
  input  logic [`BMU_XLEN-1:0]  a,
  input  logic [`BMU_XLEN-1:0]  b,
  output logic                  outValid,  // Pulse two cycles later
  output logic [`BMU_XLEN-1:0]  result
);
  import bmuPkg::*;

  aluOpT                 opQ;
  logic [`BMU_XLEN-1:0]  aQ;
  logic [`BMU_XLEN-1:0]  bQ;
  logic                  validQ;      // Stage-1 valid
  logic [`BMU_XLEN-1:0]  condShiftA;
  logic [`BMU_XLEN-1:0]  condMaskB;
  logic [`BMU_XLEN-1:0]  aluResult;
  logic [`BMU_XLEN-1:0]  bmResult;
  logic                  lt;
  logic                  ltu;

  ////////////////////
  // Stage 1
  ////////////////////
  always_ff @(posedge clk) begin
    opQ <= op;  // Loads every cycle
    aQ  <= a;
    bQ  <= b;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= inValid;
    end
  end

  aluCore alu0 (
    .op(opQ), .a(aQ), .condShiftA(condShiftA), .condMaskB(condMaskB), .b(bQ),
    .aluResult(aluResult), .lt(lt), .ltu(ltu)
  );

  bitManipAlu bmu0 (
    .op(opQ), .a(aQ), .b(bQ), .active(validQ), .aluResult(aluResult), .lt(lt), .ltu(ltu),
    .condShiftA(condShiftA), .condMaskB(condMaskB), .result(bmResult)
  );

  ////////////////////
  // Stage 2
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
      result   <= '0;
    end else begin
      outValid <= validQ;
      if (validQ) result <= bmResult;  // Holds last result when idle
    end
  end

endmodule

// File: rtl/bmuPkg.sv
// Operation codes and internal select types for the RV32 arithmetic and bit-manipulation unit
package bmuPkg;

  ////////////////////
  // Decoded operation
  ////////////////////

  // One code per supported instruction, already decoded upstream
  typedef enum logic [5:0] {
    // Base integer
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
    // Zba
    OP_SH1ADD, OP_SH2ADD, OP_SH3ADD,
    // Zbs
    OP_BSET, OP_BCLR, OP_BINV, OP_BEXT,
    // Zbb
    OP_ANDN, OP_ORN, OP_XNOR,
    OP_CLZ, OP_CTZ, OP_CPOP,
    OP_MIN, OP_MAX, OP_MINU, OP_MAXU,
    OP_SEXTB, OP_SEXTH, OP_ZEXTH,
    OP_ROL, OP_ROR, OP_ORCB, OP_REV8,
    // Zbc
    OP_CLMUL, OP_CLMULH, OP_CLMULR
  } aluOpT;

  ////////////////////
  // Internal selects
  ////////////////////

  // Final result source
  typedef enum logic [1:0] {RES_ALU, RES_ZBB, RES_ZBC} resSelT;

  // Zbb group, refined by a 2-bit sub select
  typedef enum logic [2:0] {
    ZBB_COUNT, ZBB_MINMAX, ZBB_EXTEND, ZBB_ROTATE, ZBB_ORCB, ZBB_REV8
  } zbbSelT;

  // Carry-less product half
  typedef enum logic [1:0] {CLMUL_LO, CLMUL_HI, CLMUL_REV} clmulSelT;

endpackage

// File: rtl/bmu_macros.svh
// Datapath width definitions shared by the RV32 execute-stage bit-manipulation unit
`ifndef BMU_MACROS_SVH
`define BMU_MACROS_SVH

////////////////////
// Datapath widths
////////////////////

// Integer register width, RV32 only
`define BMU_XLEN 32

// Shift and rotate amount, also the Zbs bit index
`define BMU_SHAMTW 5

// Both values have to change together,
// SHAMTW is log2 of XLEN
`endif

// File: rtl/clmulUnit.sv
// Zbc carry-less multiply returning the low, high or reversed product
`timescale 1ns/1ps
`include "bmu_macros.svh"

module clmulUnit (
  input  logic [`BMU_XLEN-1:0]  a,
  input  logic [`BMU_XLEN-1:0]  b,
  input  bmuPkg::clmulSelT      clmulSel,
  output logic [`BMU_XLEN-1:0]  clmulResult
);
  import bmuPkg::*;

  logic [2*`BMU_XLEN-1:0] prod;  // Top bit always zero

  ////////////////////
  // XOR accumulation
  ////////////////////
  // One partial product per set bit of b
  always_comb begin
    prod = '0;
    for (int i = 0; i < `BMU_XLEN; i++) begin
      if (b[i]) prod = prod ^ ({{`BMU_XLEN{1'b0}}, a} << i);
    end
  end

  // Half select
  always_comb begin
    case (clmulSel)
      CLMUL_LO: clmulResult = prod[`BMU_XLEN-1:0];
      CLMUL_HI: clmulResult = prod[2*`BMU_XLEN-1:`BMU_XLEN];
      // clmulr, product bits 62:31
      default:  clmulResult = prod[2*`BMU_XLEN-2:`BMU_XLEN-1];
    endcase
  end

endmodule

// File: rtl/zbbUnit.sv
// Zbb basic bit-manipulation: counts, min/max, extension, rotate, orc.b and rev8
`timescale 1ns/1ps
`include "bmu_macros.svh"

module zbbUnit (
  input  logic [`BMU_XLEN-1:0]  a,
  input  logic [`BMU_XLEN-1:0]  b,
  input  bmuPkg::zbbSelT        zbbSel,
  input  logic [1:0]            sub,        // Operation within the group
  input  logic                  lt,         // Flags borrowed from the adder
  input  logic                  ltu,
  output logic [`BMU_XLEN-1:0]  zbbResult
);
  import bmuPkg::*;

  localparam int CNTW   = $clog2(`BMU_XLEN) + 1;  // Count reaches XLEN
  localparam int NBYTES = `BMU_XLEN / 8;

  logic [`BMU_XLEN-1:0]    cntIn;    // A, or A reversed for ctz
  logic [CNTW-1:0]         lzc;
  logic [3:0]              byteCnt [NBYTES];
  logic [CNTW-1:0]         popCnt;
  logic [CNTW-1:0]         cnt;
  logic                    pickA;
  logic [`BMU_SHAMTW-1:0]  rotAmt;
  logic [2*`BMU_XLEN-1:0]  rotWide;
  logic [`BMU_XLEN-1:0]    extRes;
  logic [`BMU_XLEN-1:0]    orcRes;
  logic [`BMU_XLEN-1:0]    rev8Res;

  ////////////////////
  // Counts
  ////////////////////
  always_comb begin
    lzc = CNTW'(`BMU_XLEN);  // All zero
    for (int i = 0; i < `BMU_XLEN; i++) begin
      cntIn[i] = (sub == 2'd1) ? a[`BMU_XLEN-1-i] : a[i];
    end
    // Highest set bit wins
    for (int i = 0; i < `BMU_XLEN; i++) begin
      if (cntIn[i]) lzc = CNTW'(`BMU_XLEN - 1 - i);
    end
  end

  // Popcount, per byte then summed
  always_comb begin
    popCnt = '0;
    for (int i = 0; i < NBYTES; i++) begin
      byteCnt[i] = '0;
      for (int j = 0; j < 8; j++) begin
        byteCnt[i] = byteCnt[i] + 4'(a[8*i+j]);
      end
      popCnt = popCnt + CNTW'(byteCnt[i]);
    end
  end

  assign cnt = sub[1] ? popCnt : lzc;

  // sub[0] picks max, sub[1] unsigned
  assign pickA = (sub[1] ? ltu : lt) ^ sub[0];

  // Rotate right by amount, rol as right by the negated amount
  assign rotAmt  = sub[0] ? b[`BMU_SHAMTW-1:0] : -b[`BMU_SHAMTW-1:0];
  assign rotWide = {a, a} >> rotAmt;

  always_comb begin
    case (sub)
      2'd0:    extRes = {{(`BMU_XLEN-8){a[7]}}, a[7:0]};     // sext.b
      2'd1:    extRes = {{(`BMU_XLEN-16){a[15]}}, a[15:0]};  // sext.h
      default: extRes = {{(`BMU_XLEN-16){1'b0}}, a[15:0]};   // zext.h
    endcase
  end

  always_comb begin
    for (int i = 0; i < NBYTES; i++) begin
      orcRes[8*i +: 8]  = (|a[8*i +: 8]) ? 8'hff : 8'h00;
      rev8Res[8*i +: 8] = a[`BMU_XLEN-8-8*i +: 8];
    end
  end

  always_comb begin
    case (zbbSel)
      ZBB_COUNT:  zbbResult = {{(`BMU_XLEN-CNTW){1'b0}}, cnt};
      ZBB_MINMAX: zbbResult = pickA ? a : b;
      ZBB_EXTEND: zbbResult = extRes;
      ZBB_ROTATE: zbbResult = rotWide[`BMU_XLEN-1:0];
      ZBB_ORCB:   zbbResult = orcRes;
      default:    zbbResult = rev8Res;
    endcase
  end

endmodule

// File: test/bmuExecute_checker.sv
// Bound assertions on reset quiet time and the fixed two-cycle valid latency of the execute unit
`timescale 1ns/1ps

module bmuExecute_checker (
  input logic clk,
  input logic rstN,
  input logic inValid,
  input logic outValid
);

  int assertFails = 0;  // Summed into the testbench error count

  ////////////////////
  // Reset
  ////////////////////
  // Low through reset and the first cycle after release
  resetQuiet: assert property (@(posedge clk) !rstN |=> !outValid [*2])
    else begin
      assertFails++;
      $error("outValid was high during reset or in the cycle after it");
    end

  ////////////////////
  // Latency
  ////////////////////
  validLatency: assert property (@(posedge clk) disable iff (!rstN) inValid |-> ##2 outValid)
    else begin
      assertFails++;
      $error("outValid did not follow an accepted command after two cycles");
    end

  // No pulse without a command two edges back
  noSpuriousValid: assert property (@(posedge clk) disable iff (!rstN)
                                    outValid |-> $past(inValid && rstN, 2))
    else begin
      assertFails++;
      $error("outValid pulsed without a matching command");
    end

endmodule

bind bmuExecute bmuExecute_checker check0 (
  .clk(clk), .rstN(rstN), .inValid(inValid), .outValid(outValid)
);

// File: test/bmuExecute_tb.sv
// Table-driven testbench for the execute unit with a reference model and LFSR operands
`timescale 1ns/1ps
`include "bmu_macros.svh"

module bmuExecute_tb;
  import bmuPkg::*;

  localparam int XLEN = `BMU_XLEN;

  typedef struct {
    string          name;
    aluOpT          op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] exp;
    int             gap;   // Idle cycles before issue
  } rowT;

  logic            clk;
  logic            rstN;
  logic            inValid;
  aluOpT           op;
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic            outValid;
  logic [XLEN-1:0] result;

  rowT             rows[$];
  logic [XLEN-1:0] expQ[$];   // Expected results in issue order
  string           nameQ[$];
  logic [XLEN-1:0] expVal;
  string           expName;
  logic [31:0]     lfsrState;
  int              mismatches = 0;
  int              otherErrors = 0;  // Timeouts, stray pulses

  bmuExecute dut0 (
    .clk(clk), .rstN(rstN), .inValid(inValid), .op(op), .a(a), .b(b),
    .outValid(outValid), .result(result)
  );

  always #4 clk = ~clk;  // 8 ns period

  ////////////////////
  // Helpers
  ////////////////////
  // Galois step with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic takeBits(input int n, output logic [XLEN-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[XLEN-2:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);  // One step per bit
    end
  endtask

  // Spec-level behavior of every operation
  function automatic logic [XLEN-1:0] refModel(input aluOpT o, input logic [XLEN-1:0] x,
                                               input logic [XLEN-1:0] y);
    logic [XLEN-1:0] r;
    int              sh;
    sh = int'(y[4:0]);
    r  = '0;
    case (o)
      OP_ADD:    r = x + y;
      OP_SUB:    r = x - y;
      OP_AND:    r = x & y;
      OP_OR:     r = x | y;
      OP_XOR:    r = x ^ y;
      OP_SLT:    r = ($signed(x) < $signed(y)) ? 1 : 0;
      OP_SLTU:   r = (x < y) ? 1 : 0;
      OP_SLL:    r = x << sh;
      OP_SRL:    r = x >> sh;
      OP_SRA:    r = $signed(x) >>> sh;
      OP_SH1ADD: r = (x << 1) + y;
      OP_SH2ADD: r = (x << 2) + y;
      OP_SH3ADD: r = (x << 3) + y;
      OP_BSET:   r = x | (32'h1 << sh);
      OP_BCLR:   r = x & ~(32'h1 << sh);
      OP_BINV:   r = x ^ (32'h1 << sh);
      OP_BEXT:   r = (x >> sh) & 32'h1;
      OP_ANDN:   r = x & ~y;
      OP_ORN:    r = x | ~y;
      OP_XNOR:   r = ~(x ^ y);
      OP_CLZ:    for (int i = XLEN - 1; i >= 0 && !x[i]; i--) r++;
      OP_CTZ:    for (int i = 0; i < XLEN && !x[i]; i++) r++;
      OP_CPOP:   for (int i = 0; i < XLEN; i++) r = r + x[i];
      OP_MIN:    r = ($signed(x) < $signed(y)) ? x : y;
      OP_MAX:    r = ($signed(x) < $signed(y)) ? y : x;
      OP_MINU:   r = (x < y) ? x : y;
      OP_MAXU:   r = (x < y) ? y : x;
      OP_SEXTB:  r = {{24{x[7]}}, x[7:0]};
      OP_SEXTH:  r = {{16{x[15]}}, x[15:0]};
      OP_ZEXTH:  r = {16'h0, x[15:0]};
      OP_ROL:    r = (x << sh) | (x >> (XLEN - sh));  // Shift by XLEN gives zero
      OP_ROR:    r = (x >> sh) | (x << (XLEN - sh));
      OP_ORCB:   for (int i = 0; i < 4; i++) r[8*i +: 8] = (x[8*i +: 8] != 0) ? 8'hff : 8'h00;
      OP_REV8:   r = {x[7:0], x[15:8], x[23:16], x[31:24]};
      OP_CLMUL:  for (int i = 0; i < XLEN; i++) if (y[i]) r = r ^ (x << i);
      OP_CLMULH: for (int i = 1; i < XLEN; i++) if (y[i]) r = r ^ (x >> (XLEN - i));
      OP_CLMULR: for (int i = 0; i < XLEN; i++) if (y[i]) r = r ^ (x >> (XLEN - 1 - i));
      default:   r = '0;
    endcase
    return r;
  endfunction

  task automatic addRow(input string n, input aluOpT o, input logic [XLEN-1:0] x,
                        input logic [XLEN-1:0] y, input logic [XLEN-1:0] e, input int g);
    rowT row;
    row.name = n;
    row.op   = o;
    row.a    = x;
    row.b    = y;
    row.exp  = e;
    row.gap  = g;
    rows.push_back(row);
  endtask

  task automatic compare(input string n, input logic [XLEN-1:0] e, input logic [XLEN-1:0] act);
    if (act !== e) begin
      $display("Mismatch %s: expected %h, actual %h", n, e, act);
      mismatches++;
    end
  endtask

  // Hand-computed corners
  task automatic fillTable();
    addRow("add", OP_ADD, 32'h7, 32'h5, 32'hc, 0);
    addRow("add_wrap", OP_ADD, 32'hffffffff, 32'h1, 32'h0, 0);
    addRow("sub_neg", OP_SUB, 32'h3, 32'h5, 32'hfffffffe, 0);
    addRow("and", OP_AND, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000, 0);
    addRow("or", OP_OR, 32'hf0f0f0f0, 32'h0f0f0000, 32'hfffff0f0, 0);
    addRow("xor", OP_XOR, 32'haaaaaaaa, 32'hffffffff, 32'h55555555, 0);
    addRow("slt", OP_SLT, 32'hffffffff, 32'h1, 32'h1, 0);
    addRow("sltu", OP_SLTU, 32'hffffffff, 32'h1, 32'h0, 0);
    addRow("sll_31", OP_SLL, 32'h1, 32'h1f, 32'h80000000, 0);
    addRow("srl_31", OP_SRL, 32'h80000000, 32'h1f, 32'h1, 0);
    addRow("sra_31", OP_SRA, 32'h80000000, 32'h1f, 32'hffffffff, 0);
    addRow("sra_neg", OP_SRA, 32'hf0000000, 32'h4, 32'hff000000, 0);
    addRow("sh1add", OP_SH1ADD, 32'h5, 32'h3, 32'hd, 0);
    addRow("sh2add", OP_SH2ADD, 32'h5, 32'h3, 32'h17, 0);
    addRow("sh3add", OP_SH3ADD, 32'h5, 32'h3, 32'h2b, 0);
    addRow("bset_hi", OP_BSET, 32'h0, 32'h1f, 32'h80000000, 0);
    addRow("bset_idx", OP_BSET, 32'h0, 32'h23, 32'h8, 0);  // Upper index bits ignored
    addRow("bclr", OP_BCLR, 32'hffffffff, 32'h0, 32'hfffffffe, 0);
    addRow("binv", OP_BINV, 32'h12345678, 32'h4, 32'h12345668, 0);
    addRow("bext", OP_BEXT, 32'h80000000, 32'h1f, 32'h1, 0);
    addRow("andn", OP_ANDN, 32'hffff0000, 32'h0f0f0f0f, 32'hf0f00000, 0);
    addRow("orn", OP_ORN, 32'h0, 32'hffff0000, 32'h0000ffff, 0);
    addRow("xnor", OP_XNOR, 32'h0, 32'h0, 32'hffffffff, 0);
    addRow("clz_zero", OP_CLZ, 32'h0, 32'h0, 32'h20, 0);
    addRow("clz", OP_CLZ, 32'h00010000, 32'h0, 32'hf, 0);
    addRow("ctz_zero", OP_CTZ, 32'h0, 32'h0, 32'h20, 0);
    addRow("ctz", OP_CTZ, 32'h00010000, 32'h0, 32'h10, 0);
    addRow("cpop_ones", OP_CPOP, 32'hffffffff, 32'h0, 32'h20, 0);
    addRow("min", OP_MIN, 32'hffffffff, 32'h1, 32'hffffffff, 0);
    addRow("max", OP_MAX, 32'hffffffff, 32'h1, 32'h1, 0);
    addRow("minu", OP_MINU, 32'hffffffff, 32'h1, 32'h1, 0);
    addRow("maxu", OP_MAXU, 32'hffffffff, 32'h1, 32'hffffffff, 0);
    addRow("sextb", OP_SEXTB, 32'h00000080, 32'h0, 32'hffffff80, 0);
    addRow("sexth", OP_SEXTH, 32'h00008000, 32'h0, 32'hffff8000, 0);
    addRow("zexth", OP_ZEXTH, 32'hffff1234, 32'h0, 32'h00001234, 0);
    addRow("rol", OP_ROL, 32'h80000001, 32'h1, 32'h00000003, 0);
    addRow("ror", OP_ROR, 32'h80000001, 32'h1, 32'hc0000000, 0);
    addRow("orcb", OP_ORCB, 32'h00100001, 32'h0, 32'h00ff00ff, 0);
    addRow("rev8", OP_REV8, 32'h12345678, 32'h0, 32'h78563412, 0);
    addRow("clmul", OP_CLMUL, 32'h3, 32'h3, 32'h5, 0);
    addRow("clmulh", OP_CLMULH, 32'h80000000, 32'h2, 32'h1, 0);
    addRow("clmulr", OP_CLMULR, 32'h80000000, 32'h80000000, 32'h80000000, 0);
  endtask

  ////////////////////
  // Result check
  ////////////////////
  always @(negedge clk) begin
    if (rstN && outValid) begin
      if (expQ.size() == 0) begin
        $display("outValid pulsed with no command in flight");
        otherErrors++;
      end else begin
        expVal  = expQ.pop_front();
        expName = nameQ.pop_front();
        compare(expName, expVal, result);
      end
    end else if (!rstN && outValid === 1'b1) begin
      $display("outValid was high while reset was asserted");
      otherErrors++;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    aluOpT           opv;
    logic [XLEN-1:0] av;
    logic [XLEN-1:0] bv;
    logic [XLEN-1:0] g;
    int              waited;
    int              total;
    clk       = 1'b0;
    rstN      = 1'b0;
    inValid   = 1'b0;
    op        = OP_ADD;
    a         = '0;
    b         = '0;
    lfsrState = 32'hf3b5f101;

    fillTable();
    // Every op eight times with random operands and gaps
    for (int r = 0; r < 8; r++) begin
      opv = opv.first();
      for (int k = 0; k < opv.num(); k++) begin
        takeBits(XLEN, av);
        takeBits(XLEN, bv);
        takeBits(2, g);
        addRow($sformatf("rand%0d_%s", r, opv.name()), opv, av, bv, refModel(opv, av, bv),
               (g < 2) ? 0 : int'(g) - 1);
        opv = opv.next();
      end
    end

    repeat (10) @(posedge clk);
    // Outputs cleared by reset
    compare("reset_valid", '0, {{(XLEN-1){1'b0}}, outValid});
    compare("reset_result", '0, result);
    rstN <= 1'b1;

    foreach (rows[i]) begin
      repeat (rows[i].gap) begin
        inValid <= 1'b0;
        @(posedge clk);
      end
      inValid <= 1'b1;
      op      <= rows[i].op;
      a       <= rows[i].a;
      b       <= rows[i].b;
      expQ.push_back(rows[i].exp);
      nameQ.push_back(rows[i].name);
      @(posedge clk);
    end
    inValid <= 1'b0;

    // Drain the pipeline
    waited = 0;
    while (expQ.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (expQ.size() != 0) begin
      $display("Timeout: outValid never came for %0d commands", expQ.size());
      otherErrors++;
    end
    repeat (4) @(posedge clk);  // Catch stray pulses

    total = mismatches + otherErrors + dut0.check0.assertFails;
    $display("Errors: %0d mismatches, %0d protocol, %0d assertion failures",
             mismatches, otherErrors, dut0.check0.assertFails);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
